/* tsn_tag_settings.svh */
`ifndef TSN_TAG_SETTINGS_SVH
`define TSN_TAG_SETTINGS_SVH

// flow table size
`define TSN_FLOW_NUM  16
`define TSN_FLOW_W    4

// tag bytes replace the destination mac
`define TSN_TAG_BYTES 6

// ethertype rewrite on hit
`define TSN_ETYPE_POS 12
`define TSN_ETYPE_VAL 16'h1800

// byte index counter width
`define TSN_CNT_W     12

`endif

/* tsn_tag_pkg.sv */
`include "tsn_tag_settings.svh"

package tsn_tag_pkg;

    ////////////////////////////////////////
    // byte stream
    ////////////////////////////////////////

    // one stream beat with start marker
    typedef struct packed {
        logic       sop;
        logic [7:0] data;
    } pkt_byte_t;

    typedef enum logic [2:0] {
        PKT_TS   = 3'd0,
        PKT_RC   = 3'd1,
        PKT_BE   = 3'd2,
        PKT_PTP  = 3'd3,
        PKT_NMAC = 3'd4
    } pkt_type_e;

    // table entry, also the per-packet descriptor
    typedef struct packed {
        logic [`TSN_TAG_BYTES*8-1:0] tsntag;
        pkt_type_e                   pkt_type;
        logic                        hit;
        logic                        replication;
        logic                        std_tsn;
    } tag_info_t;

    ////////////////////////////////////////
    // wishbone classic
    ////////////////////////////////////////

    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        logic [7:0]  adr;
        logic [31:0] dat;
    } wb_req_t;

    typedef struct packed {
        logic        ack;
        logic [31:0] dat;
    } wb_rsp_t;

    typedef enum logic [1:0] {
        ST_IDLE = 2'd0,
        ST_TAG  = 2'd1,
        ST_PASS = 2'd2
    } ttp_state_e;

    // steers the substituter per byte
    typedef enum logic [1:0] {
        MODE_OFF  = 2'd0,
        MODE_TAG  = 2'd1,
        MODE_PASS = 2'd2
    } sub_mode_e;

endpackage

/* flow_tag_table.sv */
`timescale 1ns/1ps
`include "tsn_tag_settings.svh"

module flow_tag_table (
    input  logic                   i_clk,
    input  logic                   i_rst_n,
    input  tsn_tag_pkg::wb_req_t   i_wb,
    output tsn_tag_pkg::wb_rsp_t   o_wb,
    input  logic [`TSN_FLOW_W-1:0] i_flow_id,
    output tsn_tag_pkg::tag_info_t o_lookup
);

    tsn_tag_pkg::tag_info_t entry_q [`TSN_FLOW_NUM];
    tsn_tag_pkg::tag_info_t wb_entry;
    logic                   ack_q;
    logic [31:0]            rdat_q;
    logic                   wb_req;
    logic                   wb_take;
    logic [`TSN_FLOW_W-1:0] wb_flow;
    logic [1:0]             wb_word;

    ////////////////////////////////////////
    // wishbone decode
    ////////////////////////////////////////

    assign wb_req   = i_wb.cyc & i_wb.stb;
    // one ack per request, never on two cycles in a row
    assign wb_take  = wb_req & ~ack_q;
    // word address is {flow, word select}
    assign wb_flow  = i_wb.adr[4 +: `TSN_FLOW_W];
    assign wb_word  = i_wb.adr[3:2];
    assign wb_entry = entry_q[wb_flow];

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= wb_take;
        end
    end

    // read data lines up with ack
    always_ff @(posedge i_clk) begin
        if (wb_take && !i_wb.we) begin
            case (wb_word)
                2'd0: rdat_q <= wb_entry.tsntag[31:0];
                2'd1: rdat_q <= {wb_entry.hit, 10'd0, wb_entry.std_tsn,
                                 wb_entry.replication, wb_entry.pkt_type,
                                 wb_entry.tsntag[47:32]};
                default: rdat_q <= 32'd0;
            endcase
        end
    end

    assign o_wb = '{ack: ack_q, dat: rdat_q};

    ////////////////////////////////////////
    // entry storage
    ////////////////////////////////////////

    // all flows start invalid
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            for (int i = 0; i < `TSN_FLOW_NUM; i++) begin
                entry_q[i] <= '0;
            end
        end else if (wb_take && i_wb.we) begin
            case (wb_word)
                2'd0: entry_q[wb_flow].tsntag[31:0] <= i_wb.dat;
                2'd1: begin
                    entry_q[wb_flow].tsntag[47:32] <= i_wb.dat[15:0];
                    entry_q[wb_flow].pkt_type <= tsn_tag_pkg::pkt_type_e'(i_wb.dat[18:16]);
                    entry_q[wb_flow].replication <= i_wb.dat[19];
                    entry_q[wb_flow].std_tsn <= i_wb.dat[20];
                    entry_q[wb_flow].hit <= i_wb.dat[31];
                end
                default: begin
                end
            endcase
        end
    end

    // hit comes straight from the valid bit
    assign o_lookup = entry_q[i_flow_id];

endmodule

/* pkt_byte_counter.sv */
`timescale 1ns/1ps
`include "tsn_tag_settings.svh"

module pkt_byte_counter (
    input  logic                  i_clk,
    input  logic                  i_rst_n,
    input  logic                  i_data_wr,
    input  logic                  i_sop,
    output logic [`TSN_CNT_W-1:0] o_byte_idx
);

    localparam logic [`TSN_CNT_W-1:0] CNT_ONE = 1;
    localparam logic [`TSN_CNT_W-1:0] CNT_MAX = '1;

    logic [`TSN_CNT_W-1:0] cnt_q;

    // count holds the index of the next byte
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            cnt_q <= '0;
        end else if (!i_data_wr) begin
            // strobe low ends the packet
            cnt_q <= '0;
        end else if (i_sop) begin
            cnt_q <= CNT_ONE;
        end else if (cnt_q != CNT_MAX) begin
            // saturate so long frames never wrap into the tag bytes
            cnt_q <= cnt_q + CNT_ONE;
        end
    end

    // start byte is always index 0
    assign o_byte_idx = i_sop ? '0 : cnt_q;

endmodule

/* tag_insert_fsm.sv */
`timescale 1ns/1ps

module tag_insert_fsm (
    input  logic                   i_clk,
    input  logic                   i_rst_n,
    input  logic                   i_data_wr,
    input  logic                   i_sop,
    input  tsn_tag_pkg::tag_info_t i_lookup,
    output tsn_tag_pkg::sub_mode_e o_mode,
    output tsn_tag_pkg::tag_info_t o_info
);

    tsn_tag_pkg::ttp_state_e state_q;
    tsn_tag_pkg::ttp_state_e state_d;
    tsn_tag_pkg::ttp_state_e start_st;
    tsn_tag_pkg::tag_info_t  info_q;
    logic                    pkt_start;

    assign pkt_start = i_data_wr & i_sop;
    assign start_st  = i_lookup.hit ? tsn_tag_pkg::ST_TAG : tsn_tag_pkg::ST_PASS;

    ////////////////////////////////////////
    // next state
    ////////////////////////////////////////

    always_comb begin
        state_d = state_q;
        case (state_q)
            tsn_tag_pkg::ST_IDLE: begin
                if (pkt_start) begin
                    state_d = start_st;
                end
            end
            tsn_tag_pkg::ST_TAG, tsn_tag_pkg::ST_PASS: begin
                // a start byte with no gap opens the next packet
                if (pkt_start) begin
                    state_d = start_st;
                end else if (!i_data_wr) begin
                    state_d = tsn_tag_pkg::ST_IDLE;
                end
            end
            default: state_d = tsn_tag_pkg::ST_IDLE;
        endcase
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state_q <= tsn_tag_pkg::ST_IDLE;
            info_q  <= '0;
        end else begin
            state_q <= state_d;
            if (pkt_start) begin
                info_q <= i_lookup;
            end else if (state_d == tsn_tag_pkg::ST_IDLE) begin
                info_q <= '0;
            end
        end
    end

    // mode covers the byte on the input now
    always_comb begin
        o_mode = tsn_tag_pkg::MODE_OFF;
        if (pkt_start) begin
            o_mode = i_lookup.hit ? tsn_tag_pkg::MODE_TAG : tsn_tag_pkg::MODE_PASS;
        end else if (i_data_wr && state_q == tsn_tag_pkg::ST_TAG) begin
            o_mode = tsn_tag_pkg::MODE_TAG;
        end else if (i_data_wr && state_q == tsn_tag_pkg::ST_PASS) begin
            o_mode = tsn_tag_pkg::MODE_PASS;
        end
    end

    assign o_info = info_q;

endmodule

/* byte_substitute.sv */
`timescale 1ns/1ps
`include "tsn_tag_settings.svh"

module byte_substitute (
    input  logic                        i_clk,
    input  logic                        i_rst_n,
    input  logic                        i_data_wr,
    input  tsn_tag_pkg::pkt_byte_t      i_byte,
    input  tsn_tag_pkg::sub_mode_e      i_mode,
    input  logic [`TSN_CNT_W-1:0]       i_byte_idx,
    input  logic [`TSN_TAG_BYTES*8-1:0] i_tsntag,
    output logic                        o_data_wr,
    output tsn_tag_pkg::pkt_byte_t      o_byte
);

    localparam int          TAG_BYTES = `TSN_TAG_BYTES;
    localparam int          ETYPE_POS = `TSN_ETYPE_POS;
    localparam logic [15:0] ETYPE     = `TSN_ETYPE_VAL;

    logic [TAG_BYTES*8-1:0] tag_q;
    logic [TAG_BYTES*8-1:0] tag_cur;
    logic [7:0]             tag_byte;
    tsn_tag_pkg::pkt_byte_t byte_d;

    // flow id is only valid on the start byte so its tag is held here
    always_ff @(posedge i_clk) begin
        if (i_data_wr && i_byte.sop) begin
            tag_q <= i_tsntag;
        end
    end

    assign tag_cur = i_byte.sop ? i_tsntag : tag_q;

    // most significant tag byte first
    always_comb begin
        tag_byte = 8'd0;
        for (int i = 0; i < TAG_BYTES; i++) begin
            if (int'(i_byte_idx) == i) begin
                tag_byte = tag_cur[(TAG_BYTES-1-i)*8 +: 8];
            end
        end
    end

    ////////////////////////////////////////
    // substitution
    ////////////////////////////////////////

    always_comb begin
        byte_d = '0;
        if (i_data_wr && i_mode != tsn_tag_pkg::MODE_OFF) begin
            byte_d = i_byte;
            if (i_mode == tsn_tag_pkg::MODE_TAG) begin
                if (int'(i_byte_idx) < TAG_BYTES) begin
                    byte_d.data = tag_byte;
                end else if (int'(i_byte_idx) == ETYPE_POS) begin
                    byte_d.data = ETYPE[15:8];
                end else if (int'(i_byte_idx) == ETYPE_POS + 1) begin
                    byte_d.data = ETYPE[7:0];
                end
            end
        end
    end

    // one cycle through with gaps kept
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_data_wr <= 1'b0;
            o_byte    <= '0;
        end else begin
            o_data_wr <= i_data_wr;
            o_byte    <= byte_d;
        end
    end

endmodule

/* tsn_tag_process_top.sv */
`timescale 1ns/1ps
`include "tsn_tag_settings.svh"

module tsn_tag_process_top (
    input  logic                   i_clk,
    input  logic                   i_rst_n,

    // byte stream in
    input  logic                   i_data_wr,
    input  tsn_tag_pkg::pkt_byte_t i_byte,
    input  logic [`TSN_FLOW_W-1:0] i_flow_id,

    // byte stream out with descriptor
    output logic                   o_data_wr,
    output tsn_tag_pkg::pkt_byte_t o_byte,
    output tsn_tag_pkg::tag_info_t o_info,

    // table config
    input  tsn_tag_pkg::wb_req_t   i_wb,
    output tsn_tag_pkg::wb_rsp_t   o_wb
);

    tsn_tag_pkg::tag_info_t lookup;
    tsn_tag_pkg::sub_mode_e mode;
    logic [`TSN_CNT_W-1:0]  byte_idx;

    flow_tag_table u_table (
        .i_clk     (i_clk),
        .i_rst_n   (i_rst_n),
        .i_wb      (i_wb),
        .o_wb      (o_wb),
        .i_flow_id (i_flow_id),
        .o_lookup  (lookup)
    );

    pkt_byte_counter u_counter (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_data_wr  (i_data_wr),
        .i_sop      (i_byte.sop),
        .o_byte_idx (byte_idx)
    );

    tag_insert_fsm u_fsm (
        .i_clk     (i_clk),
        .i_rst_n   (i_rst_n),
        .i_data_wr (i_data_wr),
        .i_sop     (i_byte.sop),
        .i_lookup  (lookup),
        .o_mode    (mode),
        .o_info    (o_info)
    );

    byte_substitute u_subst (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_data_wr  (i_data_wr),
        .i_byte     (i_byte),
        .i_mode     (mode),
        .i_byte_idx (byte_idx),
        .i_tsntag   (lookup.tsntag),
        .o_data_wr  (o_data_wr),
        .o_byte     (o_byte)
    );

endmodule

/* tb_tsn_tag_process.sv */
`timescale 1ns/1ps
`include "tsn_tag_settings.svh"

module tb_tsn_tag_process;

    localparam int FW       = `TSN_FLOW_W;
    localparam int N_RAND   = 120;
    localparam int N_SHORT  = 13;
    localparam int N_B2B    = 12;
    localparam int LONG_LEN = 4200;
    localparam int NUM_PKT  = N_RAND + N_SHORT + N_B2B + 1;
    // two writes and two reads per flow
    localparam int NUM_WB   = `TSN_FLOW_NUM * 4;
    localparam int WDOG_CYC = NUM_PKT * 90 + NUM_WB * 4 + 100;

    logic                   i_clk;
    logic                   i_rst_n;
    logic                   i_data_wr;
    tsn_tag_pkg::pkt_byte_t i_byte;
    logic [FW-1:0]          i_flow_id;
    logic                   o_data_wr;
    tsn_tag_pkg::pkt_byte_t o_byte;
    tsn_tag_pkg::tag_info_t o_info;
    tsn_tag_pkg::wb_req_t   i_wb;
    tsn_tag_pkg::wb_rsp_t   o_wb;

    // reference model state
    tsn_tag_pkg::tag_info_t shadow [`TSN_FLOW_NUM];
    logic                   exp_wr;
    tsn_tag_pkg::pkt_byte_t exp_byte;
    tsn_tag_pkg::tag_info_t exp_info;
    logic [31:0]            seed;

    tsn_tag_process_top u_dut (
        .i_clk     (i_clk),
        .i_rst_n   (i_rst_n),
        .i_data_wr (i_data_wr),
        .i_byte    (i_byte),
        .i_flow_id (i_flow_id),
        .o_data_wr (o_data_wr),
        .o_byte    (o_byte),
        .o_info    (o_info),
        .i_wb      (i_wb),
        .o_wb      (o_wb)
    );

    initial begin
        i_clk = 1'b0;
    end

    always #20 i_clk = ~i_clk;

    ////////////////////////////////////////
    // error handling and random numbers
    ////////////////////////////////////////

    task automatic stop_run();
        $display("RESULT: FAIL");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic report_mismatch(input string msg);
        $display("[FAIL] t=%0t ns: %s", $time, msg);
        stop_run();
    endtask

    task automatic abort_with_note(input string msg);
        $display("%s", msg);
        stop_run();
    endtask

    function automatic logic [31:0] lcg_next();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    function automatic int rand_range(input int n);
        logic [31:0] r;
        r = lcg_next();
        return int'(r >> 8) % n;
    endfunction

    function automatic logic [7:0] rand_byte();
        logic [31:0] r;
        r = lcg_next();
        return r[23:16];
    endfunction

    function automatic logic [FW-1:0] rand_flow();
        logic [31:0] r;
        r = lcg_next();
        return r[16 +: FW];
    endfunction

    ////////////////////////////////////////
    // reference model
    ////////////////////////////////////////

    // hit rewrites dest mac with the tag and the ethertype with 0x1800
    function automatic tsn_tag_pkg::pkt_byte_t expect_byte(input tsn_tag_pkg::tag_info_t desc,
                                                          input int pos,
                                                          input tsn_tag_pkg::pkt_byte_t b);
        tsn_tag_pkg::pkt_byte_t e;
        e = b;
        if (desc.hit) begin
            if (pos < `TSN_TAG_BYTES) begin
                e.data = desc.tsntag[(`TSN_TAG_BYTES * 8 - 1) - 8 * pos -: 8];
            end else if (pos == `TSN_ETYPE_POS) begin
                e.data = 8'h18;
            end else if (pos == `TSN_ETYPE_POS + 1) begin
                e.data = 8'h00;
            end
        end
        return e;
    endfunction

    function automatic logic [31:0] read_word(input logic [FW-1:0] flow, input logic word);
        tsn_tag_pkg::tag_info_t e;
        logic [31:0]            w;
        e = shadow[flow];
        w = '0;
        if (word) begin
            // word 1 fields per the address map
            w[15:0]  = e.tsntag[47:32];
            w[18:16] = e.pkt_type;
            w[19]    = e.replication;
            w[20]    = e.std_tsn;
            w[31]    = e.hit;
        end else begin
            w = e.tsntag[31:0];
        end
        return w;
    endfunction

    // checks last cycle's outputs and idles the stream
    task automatic tick();
        @(negedge i_clk);
        assert (o_data_wr === exp_wr) else
            report_mismatch($sformatf("o_data_wr is %b, expected %b", o_data_wr, exp_wr));
        assert (o_byte === exp_byte) else
            report_mismatch($sformatf("o_byte is %h, expected %h", o_byte, exp_byte));
        assert (o_info === exp_info) else
            report_mismatch($sformatf("o_info is %h, expected %h", o_info, exp_info));
        i_data_wr = 1'b0;
        i_byte    = '0;
        i_flow_id = '0;
        exp_wr    = 1'b0;
        exp_byte  = '0;
        exp_info  = '0;
    endtask

    ////////////////////////////////////////
    // wishbone driver
    ////////////////////////////////////////

    task automatic wb_write(input logic [FW-1:0] flow, input logic word, input logic [31:0] dat);
        tick();
        i_wb.cyc = 1'b1;
        i_wb.stb = 1'b1;
        i_wb.we  = 1'b1;
        i_wb.adr = {flow, 1'b0, word, 2'b00};
        i_wb.dat = dat;
        tick();
        assert (o_wb.ack === 1'b1) else
            abort_with_note("wishbone write got no ack one cycle after the request");
        i_wb = '0;
        if (word) begin
            shadow[flow].tsntag[47:32] = dat[15:0];
            shadow[flow].pkt_type      = tsn_tag_pkg::pkt_type_e'(dat[18:16]);
            shadow[flow].replication   = dat[19];
            shadow[flow].std_tsn       = dat[20];
            shadow[flow].hit           = dat[31];
        end else begin
            shadow[flow].tsntag[31:0] = dat;
        end
        tick();
        assert (o_wb.ack === 1'b0) else
            abort_with_note("wishbone ack stayed high for a second cycle after a write");
    endtask

    task automatic wb_read(input logic [FW-1:0] flow, input logic word);
        tick();
        i_wb.cyc = 1'b1;
        i_wb.stb = 1'b1;
        i_wb.we  = 1'b0;
        i_wb.adr = {flow, 1'b0, word, 2'b00};
        i_wb.dat = '0;
        tick();
        assert (o_wb.ack === 1'b1) else
            abort_with_note("wishbone read got no ack one cycle after the request");
        assert (o_wb.dat === read_word(flow, word)) else
            report_mismatch($sformatf("read flow %0d word %0d gave %h, expected %h",
                                      flow, word, o_wb.dat, read_word(flow, word)));
        i_wb = '0;
        tick();
        assert (o_wb.ack === 1'b0) else
            abort_with_note("wishbone ack stayed high for a second cycle after a read");
    endtask

    ////////////////////////////////////////
    // stream driver
    ////////////////////////////////////////

    task automatic send_packet(input logic [FW-1:0] flow, input int len, input int gap);
        tsn_tag_pkg::tag_info_t desc;
        tsn_tag_pkg::pkt_byte_t b;
        desc = shadow[flow];
        for (int pos = 0; pos < len; pos++) begin
            tick();
            b.sop  = (pos == 0);
            b.data = rand_byte();
            i_data_wr = 1'b1;
            i_byte    = b;
            // flow id only matters on the start byte
            i_flow_id = (pos == 0) ? flow : rand_flow();
            exp_wr    = 1'b1;
            exp_byte  = expect_byte(desc, pos, b);
            exp_info  = desc;
        end
        repeat (gap) tick();
    endtask

    initial begin
        repeat (WDOG_CYC) @(posedge i_clk);
        $display("watchdog timeout after %0d clock cycles, the test did not finish", WDOG_CYC);
        stop_run();
    end

    initial begin
        logic [31:0] r;
        logic [47:0] tag;
        logic [2:0]  ptype;
        logic        valid;
        seed      = 32'd76;
        i_rst_n   = 1'b0;
        i_data_wr = 1'b0;
        i_byte    = '0;
        i_flow_id = '0;
        i_wb      = '0;
        exp_wr    = 1'b0;
        exp_byte  = '0;
        exp_info  = '0;
        for (int f = 0; f < `TSN_FLOW_NUM; f++) begin
            shadow[f] = '0;
        end
        repeat (3) tick();
        i_rst_n = 1'b1;

        // random entries with flow 0 always valid for the edge tests
        for (int f = 0; f < `TSN_FLOW_NUM; f++) begin
            r     = lcg_next();
            tag[31:0] = r;
            r     = lcg_next();
            tag[47:32] = r[31:16];
            valid = r[3] | (f == 0);
            ptype = 3'(rand_range(5));
            wb_write(FW'(f), 1'b0, tag[31:0]);
            wb_write(FW'(f), 1'b1, {valid, 10'd0, r[5], r[4], ptype, tag[47:32]});
        end
        for (int f = 0; f < `TSN_FLOW_NUM; f++) begin
            wb_read(FW'(f), 1'b0);
            wb_read(FW'(f), 1'b1);
        end

        for (int n = 0; n < N_RAND; n++) begin
            send_packet(rand_flow(), 1 + rand_range(80), rand_range(4));
        end
        // short packets end at or before the first ethertype byte
        for (int n = 1; n <= N_SHORT; n++) begin
            send_packet((n % 2 == 1) ? FW'(0) : rand_flow(), n, 1);
        end
        for (int n = 0; n < N_B2B; n++) begin
            send_packet(rand_flow(), 1 + rand_range(20), 0);
        end
        // runs the byte counter into saturation
        send_packet(FW'(0), LONG_LEN, 2);

        $display("RESULT: PASS");
        $finish;
    end

endmodule

/* verilog.f */
+incdir+.
tsn_tag_pkg.sv
flow_tag_table.sv
pkt_byte_counter.sv
tag_insert_fsm.sv
byte_substitute.sv
tsn_tag_process_top.sv
tb_tsn_tag_process.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f verilog.f --top-module tb_tsn_tag_process \
    --Mdir obj_dir -o tb_sim

./obj_dir/tb_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "RESULT: PASS" sim.log; then
    exit 0
else
    exit 1
fi
